// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_trig_process -o Vtb_trig_process
	./obj_dir/Vtb_trig_process | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: source/aux_trig_gen.sv
`timescale 1ns/1ps

module aux_trig_gen (
    input  logic                sys_clk,
    input  logic                runrst,
    input  logic                pps_i,
    input  logic [5:0]          gp_in_i,
    input  logic                pps_en_i,
    input  logic [15:0]         pps_offset_i,
    input  logic                ext_en_i,
    input  logic [2:0]          ext_sel_i,
    input  logic [15:0]         ext_offset_i,
    output trig_pkg::aux_evt_t  aux_evt_o
);

    // channel 0 is pps, channel 1 is ext
    localparam int NCHAN = 2;

    // input registers
    logic        pps_q;
    logic [5:0]  gp_q;

    // per-channel views
    logic [NCHAN-1:0] chan_lvl;
    logic [NCHAN-1:0] chan_lvl_d;
    logic [NCHAN-1:0] chan_en;
    logic [15:0]      chan_off [NCHAN];
    logic [NCHAN-1:0] rise;
    logic [NCHAN-1:0] expire;

    trig_pkg::trig_src_t src_bits;

    // one register stage on the raw inputs
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            pps_q <= 1'b0;
            gp_q  <= '0;
        end else begin
            pps_q <= pps_i;
            gp_q  <= gp_in_i;
        end
    end

    // ext line picked after the register
    assign chan_lvl    = {gp_q[ext_sel_i], pps_q};
    assign chan_en     = {ext_en_i, pps_en_i};
    assign chan_off[0] = pps_offset_i;
    assign chan_off[1] = ext_offset_i;

    // previous level for edge detect
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            chan_lvl_d <= '0;
        end else begin
            chan_lvl_d <= chan_lvl;
        end
    end

    assign rise = chan_lvl & ~chan_lvl_d;

    for (genvar c = 0; c < NCHAN; c++) begin : g_chan
        logic        busy;
        logic [15:0] cnt;
        logic        accept;

        // edges while counting are dropped
        assign accept = rise[c] && chan_en[c] && !busy;

        always_ff @(posedge sys_clk) begin
            if (runrst) begin
                busy <= 1'b0;
                cnt  <= '0;
            end else if (busy) begin
                // last count, go idle
                if (cnt == 16'd1) begin
                    busy <= 1'b0;
                end
                cnt <= cnt - 16'd1;
            end else if (accept && (chan_off[c] != 16'd0)) begin
                busy <= 1'b1;
                cnt  <= chan_off[c];
            end
        end

        // zero offset fires straight from the edge
        assign expire[c] = (busy && (cnt == 16'd1)) || (accept && (chan_off[c] == 16'd0));
    end

    // both channels expiring together share one pulse
    always_comb begin
        src_bits                    = '0;
        src_bits[trig_pkg::SRC_PPS] = expire[0];
        src_bits[trig_pkg::SRC_EXT] = expire[1];
    end

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            aux_evt_o <= '0;
        end else begin
            aux_evt_o.valid <= |expire;
            aux_evt_o.src   <= src_bits;
        end
    end

    // only six gp lines exist
    a_ext_sel_range : assert property (
        @(posedge sys_clk) disable iff (runrst)
        ext_sel_i <= 3'd5
    ) else $error("ext_sel_i selects a missing gp_in line");

endmodule

// File: source/rf_trig_collect.sv
`timescale 1ns/1ps

module rf_trig_collect #(
    parameter int NSURF = 32
) (
    input  logic                                 sys_clk,
    input  logic                                 runrst,
    input  trig_pkg::surf_word_t [NSURF-1:0]     trig_dat_i,
    input  logic                                 trig_dat_valid_i,
    input  logic [NSURF-1:0]                     trigmask_i,
    input  trig_pkg::hit_cnt_t                   rf_threshold_i,
    output trig_pkg::rf_evt_t                    rf_evt_o
);

    // trigger flags of the phase-0 word, mask already applied
    logic [NSURF-1:0]   flag_raw;
    logic [NSURF-1:0]   hit_map;
    // marks a fresh bitmap in stage one
    logic               map_vld;
    trig_pkg::hit_cnt_t hit_cnt;
    logic               thr_pass;

    // frame tracking for the strobe check
    logic [1:0]         phase;
    logic               strobe_seen;

    // pull the flag bit out of every surf word
    always_comb begin
        for (int i = 0; i < NSURF; i++) begin
            flag_raw[i] = trig_dat_i[i][trig_pkg::SURF_TRIG_BIT];
        end
    end

    // stage one
    // only the phase-0 word is looked at, later phases ignored
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            map_vld <= 1'b0;
        end else begin
            map_vld <= trig_dat_valid_i;
        end
    end

    // bitmap is payload, loaded only on the strobe
    always_ff @(posedge sys_clk) begin
        if (trig_dat_valid_i) begin
            hit_map <= flag_raw & ~trigmask_i;
        end
    end

    // stage two
    // popcount of the latched bitmap
    always_comb begin
        hit_cnt = '0;
        for (int i = 0; i < NSURF; i++) begin
            hit_cnt = hit_cnt + trig_pkg::hit_cnt_t'(hit_map[i]);
        end
    end

    // zero threshold disables the rf trigger entirely
    assign thr_pass = (rf_threshold_i != '0) && (hit_cnt >= rf_threshold_i);

    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            rf_evt_o.valid <= 1'b0;
        end else begin
            rf_evt_o.valid <= map_vld && thr_pass;
        end
    end

    // hit count rides along with the pulse
    always_ff @(posedge sys_clk) begin
        if (map_vld) begin
            rf_evt_o.hits <= hit_cnt;
        end
    end

    // phase counter
    // restarts at 1 the cycle after each strobe, so 0 marks the next one
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            phase       <= 2'd0;
            strobe_seen <= 1'b0;
        end else begin
            if (trig_dat_valid_i) begin
                phase       <= 2'd1;
                strobe_seen <= 1'b1;
            end else begin
                phase <= phase + 2'd1;
            end
        end
    end

    // strobe lands exactly on phase 0 once framing is established
    // a missing or extra strobe breaks the 4-cycle frame
    a_strobe_framing : assert property (
        @(posedge sys_clk) disable iff (runrst)
        strobe_seen |-> (trig_dat_valid_i == (phase == 2'd0))
    ) else $error("trig_dat_valid_i out of 4-cycle framing");

endmodule

// File: source/trig_merge.sv
`timescale 1ns/1ps

module trig_merge (
    input  logic                 sys_clk,
    input  logic                 runrst,
    input  trig_pkg::rf_evt_t    rf_evt_i,
    input  trig_pkg::aux_evt_t   aux_evt_i,
    input  logic                 soft_trig_i,
    input  logic                 runstop_i,
    input  logic [7:0]           holdoff_i,
    output trig_pkg::trig_hdr_t  trig_hdr_o,
    output logic                 trig_hdr_valid_o,
    output logic [15:0]          dropped_cnt_o
);

    trig_pkg::merge_state_e state;
    logic [7:0]             hold_cnt;

    // free-running time and header sequence
    trig_pkg::trig_time_t   time_cnt;
    trig_pkg::trig_seq_t    seq_cnt;

    // merged view of this cycle's inputs
    trig_pkg::trig_src_t    src_bits;
    trig_pkg::hit_cnt_t     hits;
    logic                   any_evt;
    logic                   issue;
    logic                   drop;

    // or all sources into one source vector
    always_comb begin
        src_bits                     = aux_evt_i.valid ? aux_evt_i.src : '0;
        src_bits[trig_pkg::SRC_RF]   = rf_evt_i.valid;
        src_bits[trig_pkg::SRC_SOFT] = soft_trig_i;
    end

    // hit count only meaningful with rf present
    assign hits    = rf_evt_i.valid ? rf_evt_i.hits : '0;
    assign any_evt = rf_evt_i.valid || aux_evt_i.valid || soft_trig_i;

    // run stop wins over an armed state
    assign issue = any_evt && !runstop_i && (state == trig_pkg::ARMED);
    assign drop  = any_evt && !issue;

    // time counter, zero on the first cycle out of reset
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            time_cnt <= '0;
        end else begin
            time_cnt <= time_cnt + 1'b1;
        end
    end

    // holdoff fsm
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            state    <= trig_pkg::ARMED;
            hold_cnt <= '0;
        end else begin
            case (state)
                trig_pkg::ARMED: begin
                    // zero holdoff stays armed
                    if (issue && (holdoff_i != 8'd0)) begin
                        state    <= trig_pkg::HOLDOFF;
                        hold_cnt <= holdoff_i;
                    end
                end
                trig_pkg::HOLDOFF: begin
                    if (hold_cnt == 8'd1) begin
                        state <= trig_pkg::ARMED;
                    end
                    hold_cnt <= hold_cnt - 8'd1;
                end
                default: begin
                    state <= trig_pkg::ARMED;
                end
            endcase
        end
    end

    // header strobe and sequence
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            trig_hdr_valid_o <= 1'b0;
            seq_cnt          <= '0;
        end else begin
            trig_hdr_valid_o <= issue;
            if (issue) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // header payload, time taken at the event edge
    always_ff @(posedge sys_clk) begin
        if (issue) begin
            trig_hdr_o.time_v <= time_cnt;
            trig_hdr_o.src    <= src_bits;
            trig_hdr_o.hits   <= hits;
            trig_hdr_o.seq    <= seq_cnt;
        end
    end

    // dropped count saturates at all ones
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            dropped_cnt_o <= '0;
        end else if (drop && (dropped_cnt_o != 16'hFFFF)) begin
            dropped_cnt_o <= dropped_cnt_o + 16'd1;
        end
    end

    // holdoff never runs on an empty counter
    // an empty count would stretch the window to 256 cycles
    a_holdoff_cnt_live : assert property (
        @(posedge sys_clk) disable iff (runrst)
        (state == trig_pkg::HOLDOFF) |-> (hold_cnt != 8'd0)
    ) else $error("holdoff state with an empty counter");

endmodule

// File: source/trig_pkg.sv
package trig_pkg;

    // surf trigger word layout
    localparam int SURF_WORD_W  = 16;
    // only the top bit carries the trigger flag
    localparam int SURF_TRIG_BIT = 15;

    // widths that carry a meaning
    localparam int TIME_W = 32;
    localparam int SEQ_W  = 12;
    localparam int HIT_W  = 6;
    localparam int NSRC   = 4;

    typedef logic [SURF_WORD_W-1:0] surf_word_t;
    typedef logic [TIME_W-1:0]      trig_time_t;
    typedef logic [SEQ_W-1:0]       trig_seq_t;
    // holds up to 32 surfs
    typedef logic [HIT_W-1:0]       hit_cnt_t;
    typedef logic [NSRC-1:0]        trig_src_t;

    // bit positions inside trig_src_t
    typedef enum logic [1:0] {
        SRC_RF   = 2'd0,
        SRC_PPS  = 2'd1,
        SRC_EXT  = 2'd2,
        SRC_SOFT = 2'd3
    } trig_src_e;

    // rf coincidence result, valid is a one-cycle pulse
    typedef struct packed {
        logic     valid;
        hit_cnt_t hits;
    } rf_evt_t;

    // aux result, only pps and ext bits set
    typedef struct packed {
        logic      valid;
        trig_src_t src;
    } aux_evt_t;

    // 54-bit trigger header
    typedef struct packed {
        trig_time_t time_v;
        trig_src_t  src;
        hit_cnt_t   hits;
        trig_seq_t  seq;
    } trig_hdr_t;

    typedef enum logic {ARMED = 1'b0, HOLDOFF = 1'b1} merge_state_e;

endpackage

// File: source/trig_process_top.sv
`timescale 1ns/1ps

module trig_process_top #(
    parameter int NSURF = 32
) (
    input  logic                                sys_clk,
    input  logic                                runrst,
    // surf trigger words, framed by the phase-0 strobe
    input  trig_pkg::surf_word_t [NSURF-1:0]    trig_dat_i,
    input  logic                                trig_dat_valid_i,
    input  logic [NSURF-1:0]                    trigmask_i,
    input  trig_pkg::hit_cnt_t                  rf_threshold_i,
    // auxiliary sources
    input  logic                                pps_i,
    input  logic [5:0]                          gp_in_i,
    input  logic                                pps_en_i,
    input  logic [15:0]                         pps_offset_i,
    input  logic                                ext_en_i,
    input  logic [2:0]                          ext_sel_i,
    input  logic [15:0]                         ext_offset_i,
    // merge control
    input  logic                                soft_trig_i,
    input  logic                                runstop_i,
    input  logic [7:0]                          holdoff_i,
    // header out, plain strobe with no ready
    output trig_pkg::trig_hdr_t                 trig_hdr_o,
    output logic                                trig_hdr_valid_o,
    output logic [15:0]                         dropped_cnt_o
);

    trig_pkg::rf_evt_t  rf_evt;
    trig_pkg::aux_evt_t aux_evt;

    // rf coincidence, 2 cycles strobe to event
    rf_trig_collect #(
        .NSURF(NSURF)
    ) u_rf (
        .sys_clk          (sys_clk),
        .runrst           (runrst),
        .trig_dat_i       (trig_dat_i),
        .trig_dat_valid_i (trig_dat_valid_i),
        .trigmask_i       (trigmask_i),
        .rf_threshold_i   (rf_threshold_i),
        .rf_evt_o         (rf_evt)
    );

    // pps and ext, offset delayed
    aux_trig_gen u_aux (
        .sys_clk      (sys_clk),
        .runrst       (runrst),
        .pps_i        (pps_i),
        .gp_in_i      (gp_in_i),
        .pps_en_i     (pps_en_i),
        .pps_offset_i (pps_offset_i),
        .ext_en_i     (ext_en_i),
        .ext_sel_i    (ext_sel_i),
        .ext_offset_i (ext_offset_i),
        .aux_evt_o    (aux_evt)
    );

    // one more cycle to the header
    trig_merge u_merge (
        .sys_clk          (sys_clk),
        .runrst           (runrst),
        .rf_evt_i         (rf_evt),
        .aux_evt_i        (aux_evt),
        .soft_trig_i      (soft_trig_i),
        .runstop_i        (runstop_i),
        .holdoff_i        (holdoff_i),
        .trig_hdr_o       (trig_hdr_o),
        .trig_hdr_valid_o (trig_hdr_valid_o),
        .dropped_cnt_o    (dropped_cnt_o)
    );

endmodule

// File: tb/tb_trig_process.sv
`timescale 1ns/1ps

module tb_trig_process;

    localparam int    NSURF    = 32;
    localparam string VEC_FILE = "tb/trig_vectors.txt";

    logic                                 sys_clk;
    logic                                 runrst;
    trig_pkg::surf_word_t [NSURF-1:0]     trig_dat_i;
    logic                                 trig_dat_valid_i;
    logic [NSURF-1:0]                     trigmask_i;
    trig_pkg::hit_cnt_t                   rf_threshold_i;
    logic                                 pps_i;
    logic [5:0]                           gp_in_i;
    logic                                 pps_en_i;
    logic [15:0]                          pps_offset_i;
    logic                                 ext_en_i;
    logic [2:0]                           ext_sel_i;
    logic [15:0]                          ext_offset_i;
    logic                                 soft_trig_i;
    logic                                 runstop_i;
    logic [7:0]                           holdoff_i;
    trig_pkg::trig_hdr_t                  trig_hdr_o;
    logic                                 trig_hdr_valid_o;
    logic [15:0]                          dropped_cnt_o;

    // model state
    trig_pkg::trig_time_t tcnt;
    trig_pkg::trig_time_t evt_time;
    trig_pkg::trig_seq_t  seq_exp;
    trig_pkg::trig_hdr_t  exp_q [$];
    logic [1:0]           ph;
    logic [31:0]          rnd;
    int                   err_cnt;
    int unsigned          wd_cycles;

    // header sampled on the previous edge
    logic                 hdr_seen;
    trig_pkg::trig_hdr_t  hdr_got;

    trig_process_top #(
        .NSURF(NSURF)
    ) u_trig_process_top (
        .sys_clk          (sys_clk),
        .runrst           (runrst),
        .trig_dat_i       (trig_dat_i),
        .trig_dat_valid_i (trig_dat_valid_i),
        .trigmask_i       (trigmask_i),
        .rf_threshold_i   (rf_threshold_i),
        .pps_i            (pps_i),
        .gp_in_i          (gp_in_i),
        .pps_en_i         (pps_en_i),
        .pps_offset_i     (pps_offset_i),
        .ext_en_i         (ext_en_i),
        .ext_sel_i        (ext_sel_i),
        .ext_offset_i     (ext_offset_i),
        .soft_trig_i      (soft_trig_i),
        .runstop_i        (runstop_i),
        .holdoff_i        (holdoff_i),
        .trig_hdr_o       (trig_hdr_o),
        .trig_hdr_valid_o (trig_hdr_valid_o),
        .dropped_cnt_o    (dropped_cnt_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    // mirrors the merge time counter, zero on the first cycle after reset
    always @(posedge sys_clk) begin
        if (runrst) begin
            tcnt <= '0;
        end else begin
            tcnt <= tcnt + 32'd1;
        end
    end

    // phase-0 strobe every 4 cycles
    initial begin
        ph               = 2'd0;
        trig_dat_valid_i = 1'b0;
        forever begin
            @(posedge sys_clk);
            if (runrst) begin
                ph               <= 2'd0;
                trig_dat_valid_i <= 1'b0;
            end else begin
                ph               <= ph + 2'd1;
                trig_dat_valid_i <= (ph == 2'd3);
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_hdr(input trig_pkg::trig_hdr_t got, input trig_pkg::trig_hdr_t exp);
        if (got !== exp) begin
            $display("[FAIL] trig_hdr_o got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_dropped(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("[FAIL] dropped_cnt_o got %h expected %h", got, exp);
            err_cnt++;
        end
    endtask

    // every header must match the oldest expected one
    // compared one edge after it is sampled
    always @(posedge sys_clk) begin
        if (hdr_seen) begin
            if (exp_q.size() == 0) begin
                $display("unexpected header at time %0t", $time);
                err_cnt++;
            end else begin
                check_hdr(hdr_got, exp_q.pop_front());
            end
        end
        hdr_seen <= !runrst && trig_hdr_valid_o;
        hdr_got  <= trig_hdr_o;
    end

    // four words framed on the strobe, flags only in phase p
    task automatic send_rf(input logic [31:0] map, input int p);
        @(posedge sys_clk);
        while (ph != 2'd3) begin
            @(posedge sys_clk);
        end
        // strobe seen next edge, header 3 edges later
        evt_time = tcnt + 32'd3;
        for (int q = 0; q < 4; q++) begin
            if (q > 0) begin
                @(posedge sys_clk);
            end
            for (int i = 0; i < NSURF; i++) begin
                rnd = xorshift32(rnd);
                // low bits are noise, only bit 15 counts
                trig_dat_i[i] <= {(q == p) && map[i], rnd[14:0]};
            end
        end
        @(posedge sys_clk);
        trig_dat_i <= '0;
    endtask

    // one-cycle pulse on a source, lat is edges from drive to merge
    task automatic pulse(input int kind, input int line, input int lat);
        @(posedge sys_clk);
        evt_time = tcnt + 32'(lat);
        case (kind)
            0: pps_i <= 1'b1;
            1: gp_in_i[line] <= 1'b1;
            default: soft_trig_i <= 1'b1;
        endcase
        @(posedge sys_clk);
        pps_i       <= 1'b0;
        gp_in_i     <= '0;
        soft_trig_i <= 1'b0;
    endtask

    // sum of waits for the watchdog
    function automatic int unsigned total_waits();
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] v;
        int unsigned sum;
        sum = 0;
        fd = $fopen(VEC_FILE, "r");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if ($sscanf(line, "%c %h", op, v) == 2 && op == "W") begin
                sum += v;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        return sum;
    endfunction

    initial begin
        wd_cycles = total_waits() + 200;
        #(wd_cycles * 4);
        $display("watchdog expired after %0d cycles", wd_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] a [0:8];
        runrst = 1'b1;
        trig_dat_i = '0;
        trigmask_i = '0;
        rf_threshold_i = '0;
        pps_i = 1'b0;
        gp_in_i = '0;
        pps_en_i = 1'b0;
        pps_offset_i = '0;
        ext_en_i = 1'b0;
        ext_sel_i = '0;
        ext_offset_i = '0;
        soft_trig_i = 1'b0;
        runstop_i = 1'b0;
        holdoff_i = '0;
        err_cnt = 0;
        seq_exp = '0;
        evt_time = '0;
        rnd = 32'h8dce8940;
        repeat (4) @(posedge sys_clk);
        runrst <= 1'b0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VEC_FILE);
            err_cnt++;
        end
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h", op,
                          a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8]));
            case (op)
                "C": begin
                    @(posedge sys_clk);
                    rf_threshold_i <= a[0][5:0];
                    trigmask_i     <= a[1];
                    pps_en_i       <= a[2][0];
                    pps_offset_i   <= a[3][15:0];
                    ext_en_i       <= a[4][0];
                    ext_sel_i      <= a[5][2:0];
                    ext_offset_i   <= a[6][15:0];
                    holdoff_i      <= a[7][7:0];
                    runstop_i      <= a[8][0];
                end
                "R": send_rf(a[0], int'(a[1]));
                // register, edge detect, countdown, output reg, merge
                "P": pulse(0, 0, int'(pps_offset_i) + 3);
                "E": pulse(1, int'(a[0]), int'(ext_offset_i) + 3);
                "S": pulse(2, 0, 1);
                "W": repeat (a[0]) @(posedge sys_clk);
                "X": begin
                    exp_q.push_back({evt_time, a[0][3:0], a[1][5:0], seq_exp});
                    seq_exp = seq_exp + 12'd1;
                end
                "D": begin
                    @(posedge sys_clk);
                    check_dropped(dropped_cnt_o, a[0][15:0]);
                end
                default: begin
                    $display("unknown vector command: %s", line);
                    err_cnt++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        repeat (20) @(posedge sys_clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected headers never appeared", exp_q.size());
            err_cnt += exp_q.size();
        end
        $display("error count: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/trig_vectors.txt
# C thr mask pps_en pps_off ext_en ext_sel ext_off holdoff runstop | R map phase
# P | E line | S | W cycles | X src hits | D dropped   (all numbers hex)
W a
D 0
C 2 0 0 a 0 0 0 0 0
R 00000021 0
X 1 2
W 8
C 2 00000020 0 a 0 0 0 0 0
R 00000021 0
W 8
C 2 0 0 a 0 0 0 0 0
R 00000021 1
W 8
C 2 0 1 a 0 0 0 0 0
P
X 2 0
W 14
C 2 0 0 a 1 1 a 0 0
P
W 14
E 1
X 4 0
W 14
E 0
W 14
C 2 0 1 c 1 1 a 0 0
P
E 1
X 6 0
W 1e
S
X 8 0
W 4
C 2 0 0 a 0 1 a 8 0
S
X 8 0
W 1
S
W 14
D 1
C 2 0 1 a 0 1 a 8 1
S
W 4
P
W 14
D 3

// File: verilog.f
source/trig_pkg.sv
source/rf_trig_collect.sv
source/aux_trig_gen.sv
source/trig_merge.sv
source/trig_process_top.sv
tb/tb_trig_process.sv
